/* flist.f */
src/conv_pkg.sv
src/conv_pos_counter.sv
src/conv_ctrl.sv
src/conv_window.sv
src/conv_mac.sv
src/conv_layer.sv
testbench/tb_conv_layer.sv

/* run.sh */
#!/bin/sh
# build and run the conv_layer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_conv_layer -f flist.f \
    --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "All checks passed" sim.log; then
    exit 0
fi
exit 1

/* testbench/tb_conv_layer.sv */
module tb_conv_layer;

    timeunit 1ns;
    timeprecision 1ps;

    import conv_pkg::*;

    localparam int IMG_W       = 28;
    localparam int IMG_H       = 28;
    localparam int N_RESULTS   = (IMG_H - K + 1) * (IMG_W - K + 1);
    localparam int DRAIN_LIMIT = 200;
    localparam int LATENCY     = 2;

    logic        clk;
    logic        rst_n;
    logic        pix_valid;
    pixel_t      pix_data;
    kernel_set_t kernels;
    logic        out_valid;
    conv_out_t   out_data;

    logic [31:0] lfsr = 32'he9e6_5c5d;
    logic [7:0]  frames [2][IMG_H][IMG_W];
    conv_out_t   exp_q[$];
    int          exp_cyc_q[$];
    int          cyc = 0;
    int          got_count = 0;
    int          err_count = 0;
    int          check_count = 0;
    int          test_count = 0;
    int          err_before;

    conv_layer #(.IMG_W(IMG_W), .IMG_H(IMG_H)) dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .pix_valid (pix_valid),
        .pix_data  (pix_data),
        .kernels   (kernels),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic get_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]}; // one step per bit
        end
    endtask

    task automatic random_kernels();
        logic [31:0] v;
        for (int ch = 0; ch < N_CH; ch++) begin
            for (int t = 0; t < TAPS; t++) begin
                get_bits(8, v);
                kernels[ch].weight[t] = v[7:0];
            end
            get_bits(8, v);
            kernels[ch].bias = v[7:0];
        end
    endtask

    task automatic const_kernels(input logic [7:0] w, input logic [7:0] b);
        for (int ch = 0; ch < N_CH; ch++) begin
            for (int t = 0; t < TAPS; t++) begin
                kernels[ch].weight[t] = w;
            end
            kernels[ch].bias = b;
        end
    endtask

    task automatic random_frame(input int f);
        logic [31:0] v;
        for (int r = 0; r < IMG_H; r++) begin
            for (int c = 0; c < IMG_W; c++) begin
                get_bits(8, v);
                frames[f][r][c] = v[7:0];
            end
        end
    endtask

    task automatic fill_frame(input int f, input logic [7:0] p);
        for (int r = 0; r < IMG_H; r++) begin
            for (int c = 0; c < IMG_W; c++) begin
                frames[f][r][c] = p;
            end
        end
    endtask

    // reference results for one frame, raster order of bottom-right corners
    task automatic model_frame(input int f);
        int               sum;
        logic [ACC_W-1:0] acc;
        logic [OUT_W-1:0] scaled;
        logic [7:0]       b;
        conv_out_t        res;
        for (int r = K - 1; r < IMG_H; r++) begin
            for (int c = K - 1; c < IMG_W; c++) begin
                for (int ch = 0; ch < N_CH; ch++) begin
                    sum = 0;
                    for (int kr = 0; kr < K; kr++) begin
                        for (int kc = 0; kc < K; kc++) begin
                            sum += int'(frames[f][r-K+1+kr][c-K+1+kc])
                                   * int'(kernels[ch].weight[kr*K+kc]);
                        end
                    end
                    acc = sum[ACC_W-1:0];           // wraps mod 2^20
                    scaled = acc[ACC_W-1 -: OUT_W]; // drop FRAC_SHIFT bits
                    b = kernels[ch].bias;
                    res[ch] = scaled + {{(OUT_W-COEF_W){b[7]}}, b};
                end
                exp_q.push_back(res);
            end
        end
    endtask

    task automatic send_pixel(input logic [7:0] p, input int r, input int c);
        @(posedge clk);
        #1;
        pix_valid = 1'b1;
        pix_data  = p;
        if (r >= K - 1 && c >= K - 1) begin
            exp_cyc_q.push_back(cyc + LATENCY); // cycle with pix_valid high is cycle 0
        end
    endtask

    task automatic idle_cycle();
        logic [31:0] v;
        @(posedge clk);
        #1;
        get_bits(8, v);
        pix_valid = 1'b0;
        pix_data  = v[7:0]; // junk, must be ignored
    endtask

    task automatic insert_gap();
        logic [31:0] g;
        logic [31:0] len;
        get_bits(2, g);
        if (g[1:0] == 2'b11) begin
            get_bits(3, len);
            repeat (int'(len[2:0]) + 1) idle_cycle();
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d results never arrived", exp_q.size());
            err_count++;
            exp_q.delete();
            exp_cyc_q.delete();
        end
        repeat (4) @(posedge clk); // room for a stray result
    endtask

    task automatic run_frames(input int n_frames, input bit gaps);
        got_count = 0;
        for (int f = 0; f < n_frames; f++) begin
            model_frame(f);
        end
        for (int f = 0; f < n_frames; f++) begin
            for (int r = 0; r < IMG_H; r++) begin
                for (int c = 0; c < IMG_W; c++) begin
                    if (gaps) begin
                        insert_gap();
                    end
                    send_pixel(frames[f][r][c], r, c);
                end
            end
        end
        idle_cycle();
        drain();
    endtask

    task automatic report_test(input string name, input int n_exp, input int errs_at_start);
        check_count++;
        if (got_count != n_exp) begin
            $display("[FAIL] %t: %s gave %0d results, expected %0d",
                     $time, name, got_count, n_exp);
            err_count++;
        end
        test_count++;
        if (err_count == errs_at_start) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            $display("test %0d %s: %0d errors", test_count, name, err_count - errs_at_start);
        end
    endtask

    // compare every result beat with the model, halfway through the cycle
    always @(negedge clk) begin : monitor
        conv_out_t exp_res;
        int        exp_cyc;
        if (out_valid === 1'b1) begin
            if (exp_q.size() == 0 || exp_cyc_q.size() == 0) begin
                $display("unexpected result at %t with no window pending", $time);
                err_count++;
            end else begin
                exp_res = exp_q.pop_front();
                exp_cyc = exp_cyc_q.pop_front();
                check_count += 2;
                if (out_data !== exp_res) begin
                    $display("[FAIL] %t: result %0d is %h, expected %h",
                             $time, got_count, out_data, exp_res);
                    err_count++;
                end
                if (cyc != exp_cyc) begin
                    $display("[FAIL] %t: result %0d came in cycle %0d, expected %0d",
                             $time, got_count, cyc, exp_cyc);
                    err_count++;
                end
                got_count++;
            end
        end
    end

    initial begin
        $timeformat(-9, 0, " ns", 0);
        rst_n     = 1'b0;
        pix_valid = 1'b0;
        pix_data  = '0;
        kernels   = '0;

        // test 1: quiet output in and after reset
        err_before = err_count;
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            #1;
            check_count++;
            if (out_valid !== 1'b0) begin
                $display("[FAIL] %t: out_valid is %b during reset", $time, out_valid);
                err_count++;
            end
        end
        rst_n = 1'b1;
        for (int i = 0; i < 20; i++) begin
            @(posedge clk);
            #1;
            check_count++;
            if (out_valid !== 1'b0) begin
                $display("[FAIL] %t: out_valid is %b with no pixels", $time, out_valid);
                err_count++;
            end
        end
        got_count = 0;
        report_test("reset idle", 0, err_before);

        // test 2: one frame, no gaps
        err_before = err_count;
        random_kernels();
        random_frame(0);
        run_frames(1, 1'b0);
        report_test("random frame", N_RESULTS, err_before);

        // test 3: same flow with pix_valid gaps
        err_before = err_count;
        random_kernels();
        random_frame(0);
        run_frames(1, 1'b1);
        report_test("random frame with gaps", N_RESULTS, err_before);

        // test 4: frames back to back
        err_before = err_count;
        random_kernels();
        random_frame(0);
        random_frame(1);
        run_frames(2, 1'b0);
        report_test("two frames back to back", 2 * N_RESULTS, err_before);

        // test 5: saturating corners, wrap of sum and bias
        err_before = err_count;
        fill_frame(0, 8'hff);
        const_kernels(8'h7f, 8'h80);
        run_frames(1, 1'b0);
        report_test("max pixels, weight 127", N_RESULTS, err_before);

        err_before = err_count;
        const_kernels(8'h80, 8'h80);
        run_frames(1, 1'b1);
        report_test("max pixels, weight -128", N_RESULTS, err_before);

        $display("summary: %0d tests, %0d checks, %0d errors",
                 test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* src/conv_layer.sv */
module conv_layer #(
    parameter int IMG_W = 28,
    parameter int IMG_H = 28
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  pix_valid,
    input  conv_pkg::pixel_t      pix_data,
    input  conv_pkg::kernel_set_t kernels,
    output logic                  out_valid,
    output conv_pkg::conv_out_t   out_data
);

    import conv_pkg::*;

    localparam int COL_W = $clog2(IMG_W);
    localparam int ROW_W = $clog2(IMG_H);

    logic [COL_W-1:0] col;
    logic [ROW_W-1:0] row;
    logic             line_end;
    logic             frame_end;
    logic             win_valid;
    window_t          window;

    conv_pos_counter #(.IMG_W(IMG_W), .IMG_H(IMG_H)) u_pos_counter (
        .clk       (clk),
        .rst_n     (rst_n),
        .pix_valid (pix_valid),
        .col       (col),
        .row       (row),
        .line_end  (line_end),
        .frame_end (frame_end)
    );

    conv_ctrl #(.COL_W(COL_W), .ROW_W(ROW_W)) u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .pix_valid (pix_valid),
        .col       (col),
        .row       (row),
        .line_end  (line_end),
        .frame_end (frame_end),
        .win_valid (win_valid)
    );

    conv_window #(.IMG_W(IMG_W)) u_window (
        .clk       (clk),
        .rst_n     (rst_n),
        .pix_valid (pix_valid),
        .pix_data  (pix_data),
        .window    (window)
    );

    conv_mac u_mac (
        .clk       (clk),
        .rst_n     (rst_n),
        .win_valid (win_valid),
        .window    (window),
        .kernels   (kernels),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

/* src/conv_mac.sv */
module conv_mac (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  win_valid,
    input  conv_pkg::window_t     window,
    input  conv_pkg::kernel_set_t kernels,
    output logic                  out_valid,
    output conv_pkg::conv_out_t   out_data
);

    import conv_pkg::*;

    logic signed [ACC_W-1:0] acc [N_CH];
    conv_out_t res;

    // 25-tap product sum per channel, then scale and bias
    always_comb begin
        for (int ch = 0; ch < N_CH; ch++) begin
            acc[ch] = '0;
            for (int t = 0; t < TAPS; t++) begin
                // pixel is zero-extended so it stays positive
                acc[ch] = acc[ch] + $signed({1'b0, window[t]}) * kernels[ch].weight[t];
            end
            // top bits act as an arithmetic shift, bias add wraps at OUT_W
            res[ch] = acc[ch][FRAC_SHIFT +: OUT_W] + result_t'(kernels[ch].bias);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= win_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (win_valid) begin
            out_data <= res; // held between results
        end
    end

    // weights stay put while a window is summed
    a_kernels_stable: assert property (@(posedge clk) disable iff (!rst_n)
        win_valid |-> $stable(kernels));

endmodule

/* src/conv_window.sv */
module conv_window #(
    parameter int IMG_W = 28
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              pix_valid,
    input  conv_pkg::pixel_t  pix_data,
    output conv_pkg::window_t window
);

    import conv_pkg::*;

    // line_buf[j][IMG_W-1] is the pixel j+1 rows above the incoming one
    pixel_t line_buf [K-1][IMG_W];
    pixel_t [K-1:0] new_col; // index 0 is the top row

    always_comb begin
        for (int r = 0; r < K - 1; r++) begin
            new_col[r] = line_buf[K-2-r][IMG_W-1];
        end
        new_col[K-1] = pix_data;
    end

    // row buffers chain into each other
    always_ff @(posedge clk) begin
        if (pix_valid) begin
            for (int j = 0; j < K - 1; j++) begin
                for (int i = IMG_W - 1; i > 0; i--) begin
                    line_buf[j][i] <= line_buf[j][i-1];
                end
            end
            line_buf[0][0] <= pix_data;
            for (int j = 1; j < K - 1; j++) begin
                line_buf[j][0] <= line_buf[j-1][IMG_W-1];
            end
        end
    end

    // 5x5 window, moves one column right per accepted pixel
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            window <= '0;
        end else if (pix_valid) begin
            for (int r = 0; r < K; r++) begin
                for (int c = 0; c < K - 1; c++) begin
                    window[r*K+c] <= window[r*K+c+1];
                end
                window[r*K+K-1] <= new_col[r]; // right column is the newest
            end
        end
    end

endmodule

/* src/conv_ctrl.sv */
module conv_ctrl #(
    parameter int COL_W = 5,
    parameter int ROW_W = 5
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             pix_valid,
    input  logic [COL_W-1:0] col,
    input  logic [ROW_W-1:0] row,
    input  logic             line_end,
    input  logic             frame_end,
    output logic             win_valid
);

    import conv_pkg::*;

    localparam logic [ROW_W-1:0] LAST_FILL_ROW = ROW_W'(K - 2);
    localparam logic [ROW_W-1:0] FIRST_WIN_ROW = ROW_W'(K - 1);
    localparam logic [COL_W-1:0] FIRST_WIN_COL = COL_W'(K - 1);

    ctrl_state_e state;
    ctrl_state_e state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            FILL: begin
                // buffers hold K-1 rows once this row ends
                if (line_end && (row == LAST_FILL_ROW)) begin
                    state_nxt = SLIDE;
                end
            end
            SLIDE: begin
                if (frame_end) begin
                    state_nxt = FILL;
                end
            end
            default: state_nxt = FILL;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= FILL;
            win_valid <= 1'b0;
        end else begin
            state <= state_nxt;
            // lines up with the window register update
            win_valid <= pix_valid && (state == SLIDE) && (col >= FIRST_WIN_COL);
        end
    end

    // pixels of the first K-1 rows never yield a window
    a_no_win_in_fill: assert property (@(posedge clk) disable iff (!rst_n)
        win_valid |-> ($past(row) >= FIRST_WIN_ROW));

endmodule

/* src/conv_pos_counter.sv */
module conv_pos_counter #(
    parameter int IMG_W = 28,
    parameter int IMG_H = 28
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     pix_valid,
    output logic [$clog2(IMG_W)-1:0] col,
    output logic [$clog2(IMG_H)-1:0] row,
    output logic                     line_end,
    output logic                     frame_end
);

    localparam int COL_W = $clog2(IMG_W);
    localparam int ROW_W = $clog2(IMG_H);
    localparam logic [COL_W-1:0] COL_LAST = COL_W'(IMG_W - 1);
    localparam logic [ROW_W-1:0] ROW_LAST = ROW_W'(IMG_H - 1);

    // flags describe the pixel accepted on this edge
    assign line_end  = pix_valid && (col == COL_LAST);
    assign frame_end = line_end && (row == ROW_LAST);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            col <= '0;
            row <= '0;
        end else if (pix_valid) begin
            if (line_end) begin
                col <= '0;
                if (frame_end) begin
                    row <= '0; // next frame
                end else begin
                    row <= row + 1'b1;
                end
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    // column wraps before it can leave the image
    a_col_range: assert property (@(posedge clk) disable iff (!rst_n)
        col <= COL_LAST);

endmodule

/* src/conv_pkg.sv */
package conv_pkg;

    // data widths
    localparam int PIX_W  = 8;
    localparam int COEF_W = 8;

    // kernel geometry
    localparam int K    = 5;
    localparam int TAPS = K * K;
    localparam int N_CH = 3;

    // arithmetic
    localparam int ACC_W      = 20; // product sum, wraps mod 2^20
    localparam int OUT_W      = 12;
    localparam int FRAC_SHIFT = 8;  // sum bits dropped before bias add

    typedef logic [PIX_W-1:0] pixel_t;          // unsigned greyscale
    typedef logic signed [COEF_W-1:0] coef_t;   // weight or bias

    // tap 0 is top-left, raster order, tap TAPS-1 bottom-right
    typedef pixel_t [TAPS-1:0] window_t;

    // weight[t] pairs with window tap t
    typedef struct packed {
        coef_t [TAPS-1:0] weight;
        coef_t            bias;
    } kernel_t;

    typedef kernel_t [N_CH-1:0] kernel_set_t;

    typedef logic signed [OUT_W-1:0] result_t;
    typedef result_t [N_CH-1:0] conv_out_t;    // one result per channel

    // window controller
    typedef enum logic {
        FILL,   // first K-1 rows of a frame
        SLIDE   // window fully covered by image rows
    } ctrl_state_e;

endpackage
